//--- build.f
side_ch_pkg.sv
ring_if.sv
iq_trigger_detect.sv
iq_ring_buffer.sv
iq_capture_sequencer.sv
dma_source_select.sv
side_ch_top.sv
side_ch_checker.sv
tb_side_ch.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_side_ch
FLIST     ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_side_ch.sv
// testbench top for the IQ side channel, drives random captures, triggers and DMA modes
`timescale 1ns/1ps
`default_nettype none

module tb_side_ch import side_ch_pkg::*; ();

	localparam int MAX_PRE = 400;
	localparam int MAX_LEN = 400;
	localparam int N_WINDOWS = 28; // captures plus empty windows
	localparam int LIMIT = 1200 + N_WINDOWS * (MAX_PRE + MAX_LEN + 120) + 2000;

	logic clk, rstn, wrote;
	logic [GPIO_W-1:0] gpio_status;
	logic [RSSI_W-1:0] rssi_half_db, rssi_th;
	logic [TSF_W-1:0] tsf_runtime_val, ev_tsf;
	logic [31:0] iq0, iq1, ev_seq, rng;
	logic iq_strobe, fcs_in_strobe, fcs_ok, long_preamble_detected, short_preamble_detected;
	logic iq_capture, iq_trigger_free_run_flag, slv_reg_wren_signal, m_axis_start_ext_trigger;
	logic [0:0] iq_capture_cfg;
	trig_sel_e iq_trigger_select;
	logic [GPIO_W-2:0] gain_th;
	logic [CNT_W-1:0] pre_trigger_len, iq_len_target, m_axis_data_count;
	logic [4:0] axi_awaddr_core;
	dma_mode_e m_axis_start_mode;
	logic [DATA_W-1:0] data_to_pl, data_to_ps;
	logic emptyn_to_pl, s_axis_tlast, pl_ask_data, m_axis_start_1trans, data_to_ps_valid;
	logic check_req, in_frame, rand_status;
	int exp_caps, exp_starts, errors, captures, cycles;

	side_ch_top DUT (.*);

	side_ch_checker chk (
		.clk(clk), .rstn(rstn), .mode(m_axis_start_mode), .data_to_pl(data_to_pl),
		.emptyn_to_pl(emptyn_to_pl), .s_axis_tlast(s_axis_tlast),
		.m_axis_start_ext_trigger(m_axis_start_ext_trigger), .iq_strobe(iq_strobe),
		.iq_capture(iq_capture), .iq_capture_cfg(iq_capture_cfg), .iq0(iq0), .iq1(iq1),
		.rssi_half_db(rssi_half_db), .gpio_status(gpio_status), .pl_ask_data(pl_ask_data),
		.m_axis_start_1trans(m_axis_start_1trans), .data_to_ps(data_to_ps),
		.data_to_ps_valid(data_to_ps_valid), .pre_len(pre_trigger_len), .cap_len(iq_len_target),
		.ev_seq(ev_seq), .ev_tsf(ev_tsf), .check_req(check_req), .exp_caps(exp_caps),
		.exp_starts(exp_starts), .errors(errors), .captures(captures), .in_frame(in_frame)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) wrote <= rstn && iq_strobe && iq_capture; // sample went into the ring

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == LIMIT) begin
			$display("run stopped by timeout after %0d cycles", cycles);
			$display("Result: FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] rand_next();
		rng = rng * 32'd1664525 + 32'd1013904223;
		return rng;
	endfunction

	// all driving happens here, on the falling edge
	task automatic tick(input int n);
		logic [31:0] r;
		repeat (n) begin
			@(negedge clk);
			r = rand_next();
			tsf_runtime_val = tsf_runtime_val + 1;
			if (wrote)
				iq0 = iq0 + 1; // sequence number per strobe
			iq1 = {iq0[15:0], ~iq0[15:0]};
			m_axis_start_ext_trigger = r[27];
			if (rand_status) begin
				rssi_half_db = r[30:20];
				gpio_status  = r[15:8];
			end
		end
	endtask

	task automatic request_check();
		check_req = 1'b1;
		tick(1);
		check_req = 1'b0;
	endtask

	task automatic fire_fcs();
		fcs_in_strobe = 1'b1;
		ev_seq        = iq0;
		ev_tsf        = tsf_runtime_val;
		tick(1);
		fcs_in_strobe = 1'b0;
	endtask

	task automatic expect_capture();
		int k;
		k = 0;
		exp_caps++;
		while ((captures != exp_caps || in_frame) && k < int'(iq_len_target) + 60) begin
			tick(1);
			k++;
		end
		request_check();
	endtask

	task automatic expect_none();
		tick(int'(iq_len_target) + 60);
		request_check();
	endtask

	task automatic opcode_test(input trig_sel_e op, input logic [RSSI_W-1:0] rssi_a,
		input logic [RSSI_W-1:0] rssi_b, input logic [GPIO_W-1:0] gpio_a,
		input logic [GPIO_W-1:0] gpio_b);
		iq_trigger_select = trig_sel_e'(4'd15); // spare code while setting up
		rssi_half_db      = rssi_a;
		gpio_status       = gpio_a;
		tick(4);
		iq_trigger_select = op;
		expect_none(); // no crossing, no capture
		rssi_half_db = rssi_b;
		gpio_status  = gpio_b;
		ev_seq       = iq0;
		ev_tsf       = tsf_runtime_val;
		tick(1);
		expect_capture();
	endtask

	initial begin
		logic [31:0] r;
		rng = 32'd32;
		cycles = 0;
		rstn = 1'b0;
		{gpio_status, rssi_half_db, rssi_th, tsf_runtime_val, ev_tsf} = '0;
		{iq0, iq1, ev_seq, iq_strobe, fcs_in_strobe, fcs_ok} = '0;
		{long_preamble_detected, short_preamble_detected, iq_capture} = '0;
		{iq_trigger_free_run_flag, slv_reg_wren_signal, m_axis_start_ext_trigger} = '0;
		iq_capture_cfg = '0;
		iq_trigger_select = TRIG_FCS_OR_FREE;
		gain_th = 7'd40;
		pre_trigger_len = 14'd8;
		iq_len_target = 14'd16;
		m_axis_data_count = '0;
		axi_awaddr_core = '0;
		m_axis_start_mode = DMA_AUTO_START;
		{data_to_pl, emptyn_to_pl, s_axis_tlast} = '0;
		{check_req, rand_status} = '0;
		exp_caps = 0;
		exp_starts = 0;
		tick(16);
		rstn = 1'b1;
		tick(2);
		iq_capture = 1'b1;
		iq_strobe  = 1'b1;
		tick(1100); // fill the ring
		rand_status = 1'b1;
		for (int i = 0; i < 6; i++) begin
			r = rand_next();
			pre_trigger_len   = CNT_W'(4 + r % MAX_PRE);
			iq_len_target     = CNT_W'(1 + rand_next() % MAX_LEN);
			iq_capture_cfg    = r[20];
			m_axis_start_mode = i[0] ? DMA_EXT_START : DMA_AUTO_START;
			m_axis_data_count = CNT_W'(rand_next() % 2000);
			fire_fcs();
			expect_capture();
		end
		m_axis_start_mode = DMA_AUTO_START;
		m_axis_data_count = CNT_W'(MAX_DMA_UDP) - iq_len_target; // one word short
		fire_fcs();
		expect_none();
		m_axis_data_count = CNT_W'(MAX_DMA_UDP) - iq_len_target - 1'b1;
		fire_fcs();
		expect_capture();
		rand_status = 1'b0;
		m_axis_data_count = '0;
		iq_capture_cfg = 1'b0;
		pre_trigger_len = 14'd8;
		iq_len_target = 14'd16;
		opcode_test(TRIG_RSSI_RISE, -11'sd100, 11'sd50, 8'h0a, 8'h0a);
		opcode_test(TRIG_RSSI_FALL, 11'sd50, -11'sd100, 8'h0a, 8'h0a);
		opcode_test(TRIG_AGC_LOCK_TO_UNLOCK, -11'sd100, -11'sd100, 8'h8a, 8'h0a);
		opcode_test(TRIG_AGC_UNLOCK_TO_LOCK, -11'sd100, -11'sd100, 8'h0a, 8'h8a);
		opcode_test(TRIG_GAIN_RISE, -11'sd100, -11'sd100, 8'h0a, 8'h30);
		opcode_test(TRIG_GAIN_FALL, -11'sd100, -11'sd100, 8'h30, 8'h0a);
		iq_trigger_select = trig_sel_e'(4'd15);
		fire_fcs();
		expect_none();
		iq_trigger_select = TRIG_FCS_OR_FREE;
		m_axis_start_mode = DMA_OFF;
		fire_fcs();
		expect_none(); // capture runs but stays hidden
		m_axis_start_mode = DMA_LOOPBACK;
		repeat (64) begin
			r = rand_next();
			data_to_pl   = {r, rand_next()};
			emptyn_to_pl = r[3];
			s_axis_tlast = r[9];
			tick(1);
		end
		{data_to_pl, emptyn_to_pl, s_axis_tlast} = '0;
		m_axis_start_mode = DMA_AUTO_START;
		axi_awaddr_core = 5'd2;
		slv_reg_wren_signal = 1'b1;
		tick(3); // longer write still starts once
		slv_reg_wren_signal = 1'b0;
		tick(2);
		axi_awaddr_core = 5'd3;
		slv_reg_wren_signal = 1'b1;
		tick(2);
		slv_reg_wren_signal = 1'b0;
		exp_starts = 1;
		tick(4);
		request_check();
		tick(2);
		$display("checks done: %0d errors, %0d captures, %0d start pulses",
			errors, captures, exp_starts);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- side_ch_checker.sv
// testbench monitor, models the expected DMA streams from the DUT ports and counts mismatches
`timescale 1ns/1ps
`default_nettype none

module side_ch_checker import side_ch_pkg::*; (
	input  logic                     clk,
	input  logic                     rstn,
	input  dma_mode_e                mode,
	input  logic [DATA_W-1:0]        data_to_pl,
	input  logic                     emptyn_to_pl,
	input  logic                     s_axis_tlast,
	input  logic                     m_axis_start_ext_trigger,
	input  logic                     iq_strobe,
	input  logic                     iq_capture,
	input  logic [0:0]               iq_capture_cfg,
	input  logic [2*IQ_W-1:0]        iq0,
	input  logic [2*IQ_W-1:0]        iq1,
	input  logic [RSSI_W-1:0]        rssi_half_db,
	input  logic [GPIO_W-1:0]        gpio_status,
	input  logic                     pl_ask_data,
	input  logic                     m_axis_start_1trans,
	input  logic [DATA_W-1:0]        data_to_ps,
	input  logic                     data_to_ps_valid,
	input  logic [CNT_W-1:0]         pre_len,
	input  logic [CNT_W-1:0]         cap_len,
	input  logic [31:0]              ev_seq,
	input  logic [TSF_W-1:0]         ev_tsf,
	input  logic                     check_req,
	input  int                       exp_caps,
	input  int                       exp_starts,
	output int                       errors,
	output int                       captures,
	output logic                     in_frame
);

	logic [RSSI_W-1:0] rssi_log [0:4095]; // status seen with each sequence number
	logic [GPIO_W-1:0] gpio_log [0:4095];
	logic [31:0]       iq1_log  [0:4095];
	logic              cfg_log  [0:4095]; // packing mode when the sample was written
	int                idx;
	int                starts;
	logic [31:0]       last_seq;

	initial begin
		errors   = 0;
		captures = 0;
		idx      = 0;
		starts   = 0;
	end

	assign in_frame = (idx != 0);

	task automatic fail_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		errors++;
		$display("Fail %s: got %h, expected %h", name, got, exp);
	endtask

	task automatic check_word();
		logic [31:0]       seq;
		logic [DATA_W-1:0] expected;
		int                first_lo;
		seq      = data_to_ps[31:0];
		first_lo = int'(ev_seq) - int'(pre_len);
		if (idx == 0) begin
			captures++; // header word
			if (data_to_ps < ev_tsf || data_to_ps > ev_tsf + 3)
				fail_value("data_to_ps (header)", data_to_ps, ev_tsf);
		end else begin
			if (idx == 1) begin
				if (int'(seq) < first_lo || int'(seq) > first_lo + 2)
					fail_value("data_to_ps (first sample)", seq, first_lo);
			end else if (seq != last_seq + 1) begin
				fail_value("data_to_ps (sample seq)", seq, last_seq + 1);
			end
			last_seq = seq;
			if (cfg_log[seq[11:0]])
				expected = {iq1_log[seq[11:0]], seq};
			else
				expected = {5'b0, rssi_log[seq[11:0]], 8'b0, gpio_log[seq[11:0]], seq};
			if (data_to_ps !== expected)
				fail_value("data_to_ps", data_to_ps, expected);
		end
		idx = (idx == int'(cap_len)) ? 0 : idx + 1;
	endtask

	always @(posedge clk) begin
		if (rstn && iq_strobe && iq_capture) begin
			rssi_log[iq0[11:0]] <= rssi_half_db;
			gpio_log[iq0[11:0]] <= gpio_status;
			iq1_log[iq0[11:0]]  <= iq1;
			cfg_log[iq0[11:0]]  <= iq_capture_cfg[0];
		end
		if (rstn) begin
			case (mode)
				DMA_LOOPBACK: begin
					if (data_to_ps !== data_to_pl)
						fail_value("data_to_ps", data_to_ps, data_to_pl);
					if (data_to_ps_valid !== emptyn_to_pl)
						fail_value("data_to_ps_valid", data_to_ps_valid, emptyn_to_pl);
					if (m_axis_start_1trans !== s_axis_tlast)
						fail_value("m_axis_start_1trans", m_axis_start_1trans, s_axis_tlast);
					if (pl_ask_data !== 1'b1)
						fail_value("pl_ask_data", pl_ask_data, 1);
				end
				DMA_OFF: if (data_to_ps_valid !== 1'b0)
					fail_value("data_to_ps_valid", data_to_ps_valid, 0);
				default: begin
					if (mode == DMA_EXT_START && m_axis_start_1trans !== m_axis_start_ext_trigger)
						fail_value("m_axis_start_1trans", m_axis_start_1trans,
							m_axis_start_ext_trigger);
					if (mode == DMA_AUTO_START && m_axis_start_1trans)
						starts++;
					if (data_to_ps_valid)
						check_word();
				end
			endcase
			if (check_req) begin
				if (captures != exp_caps) begin
					errors++;
					$display("capture count is %0d but %0d were expected", captures, exp_caps);
				end
				if (idx != 0) begin
					errors++;
					$display("capture stream stopped in the middle of a frame");
				end
				if (starts != exp_starts) begin
					errors++;
					$display("saw %0d auto start pulses but %0d were expected", starts, exp_starts);
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- side_ch_top.sv
// top level of the IQ capture side channel, connects trigger, buffer, sequencer and DMA mux
`timescale 1ns/1ps
`default_nettype none

module side_ch_top import side_ch_pkg::*; (
	input  logic                     clk,
	input  logic                     rstn,
	input  logic [GPIO_W-1:0]        gpio_status,
	input  logic signed [RSSI_W-1:0] rssi_half_db,
	input  logic [TSF_W-1:0]         tsf_runtime_val,
	input  logic [2*IQ_W-1:0]        iq0,
	input  logic [2*IQ_W-1:0]        iq1,
	input  logic                     iq_strobe,
	input  logic                     fcs_in_strobe,
	input  logic                     fcs_ok,
	input  logic                     long_preamble_detected,
	input  logic                     short_preamble_detected,
	input  logic                     iq_capture,
	input  logic [0:0]               iq_capture_cfg,
	input  trig_sel_e                iq_trigger_select,
	input  logic                     iq_trigger_free_run_flag,
	input  logic signed [RSSI_W-1:0] rssi_th,
	input  logic [GPIO_W-2:0]        gain_th,
	input  logic [CNT_W-1:0]         pre_trigger_len,
	input  logic [CNT_W-1:0]         iq_len_target,
	input  logic                     slv_reg_wren_signal,
	input  logic [4:0]               axi_awaddr_core,
	input  dma_mode_e                m_axis_start_mode,
	input  logic                     m_axis_start_ext_trigger,
	input  logic [DATA_W-1:0]        data_to_pl,
	input  logic                     emptyn_to_pl,
	input  logic                     s_axis_tlast,
	input  logic [CNT_W-1:0]         m_axis_data_count,
	output logic                     pl_ask_data,
	output logic                     m_axis_start_1trans,
	output logic [DATA_W-1:0]        data_to_ps,
	output logic                     data_to_ps_valid
);

	logic              iq_trigger;
	logic [DATA_W-1:0] capture_data;
	logic              capture_valid;

	ring_if ring ();

	iq_trigger_detect u_trigger (
		.clk                     (clk),
		.rstn                    (rstn),
		.iq_capture              (iq_capture),
		.iq_trigger_select       (iq_trigger_select),
		.iq_trigger_free_run_flag(iq_trigger_free_run_flag),
		.fcs_in_strobe           (fcs_in_strobe),
		.fcs_ok                  (fcs_ok),
		.long_preamble_detected  (long_preamble_detected),
		.short_preamble_detected (short_preamble_detected),
		.rssi_half_db            (rssi_half_db),
		.rssi_th                 (rssi_th),
		.gpio_status             (gpio_status),
		.gain_th                 (gain_th),
		.iq_trigger              (iq_trigger)
	);

	iq_ring_buffer u_buffer (
		.clk           (clk),
		.rstn          (rstn),
		.iq_capture    (iq_capture),
		.iq_capture_cfg(iq_capture_cfg),
		.iq0           (iq0),
		.iq1           (iq1),
		.iq_strobe     (iq_strobe),
		.rssi_half_db  (rssi_half_db),
		.gpio_status   (gpio_status),
		.ring          (ring.buffer)
	);

	iq_capture_sequencer u_sequencer (
		.clk              (clk),
		.rstn             (rstn),
		.iq_capture       (iq_capture),
		.iq_trigger       (iq_trigger),
		.tsf_runtime_val  (tsf_runtime_val),
		.pre_trigger_len  (pre_trigger_len),
		.iq_len_target    (iq_len_target),
		.m_axis_data_count(m_axis_data_count),
		.ring             (ring.sequencer),
		.capture_data     (capture_data),
		.capture_valid    (capture_valid)
	);

	dma_source_select u_dma_select (
		.clk                     (clk),
		.rstn                    (rstn),
		.m_axis_start_mode       (m_axis_start_mode),
		.m_axis_start_ext_trigger(m_axis_start_ext_trigger),
		.slv_reg_wren_signal     (slv_reg_wren_signal),
		.axi_awaddr_core         (axi_awaddr_core),
		.data_to_pl              (data_to_pl),
		.emptyn_to_pl            (emptyn_to_pl),
		.s_axis_tlast            (s_axis_tlast),
		.capture_data            (capture_data),
		.capture_valid           (capture_valid),
		.pl_ask_data             (pl_ask_data),
		.m_axis_start_1trans     (m_axis_start_1trans),
		.data_to_ps              (data_to_ps),
		.data_to_ps_valid        (data_to_ps_valid)
	);

endmodule

`default_nettype wire

//--- dma_source_select.sv
// DMA output mux, picks loopback, auto-start capture, external-start capture or idle
`timescale 1ns/1ps
`default_nettype none

module dma_source_select import side_ch_pkg::*; (
	input  logic              clk,
	input  logic              rstn,
	input  dma_mode_e         m_axis_start_mode,
	input  logic              m_axis_start_ext_trigger,
	input  logic              slv_reg_wren_signal,
	input  logic [4:0]        axi_awaddr_core,
	input  logic [DATA_W-1:0] data_to_pl,
	input  logic              emptyn_to_pl,
	input  logic              s_axis_tlast,
	input  logic [DATA_W-1:0] capture_data,
	input  logic              capture_valid,
	output logic              pl_ask_data,
	output logic              m_axis_start_1trans,
	output logic [DATA_W-1:0] data_to_ps,
	output logic              data_to_ps_valid
);

	logic len_wr;
	logic len_wr_q;
	logic len_wr_qq;
	logic auto_start;

	assign len_wr     = slv_reg_wren_signal && (axi_awaddr_core == 5'(NUM_DMA_REG_ADDR));
	assign auto_start = len_wr_q & ~len_wr_qq; // first cycle of the write only

	always_ff @(posedge clk) begin
		if (!rstn) begin
			len_wr_q  <= 1'b0;
			len_wr_qq <= 1'b0;
		end else begin
			len_wr_q  <= len_wr;
			len_wr_qq <= len_wr_q;
		end
	end

	always_comb begin
		pl_ask_data         = 1'b0;
		m_axis_start_1trans = 1'b0;
		data_to_ps          = '0;
		data_to_ps_valid    = 1'b0;
		case (m_axis_start_mode)
			DMA_LOOPBACK: begin
				pl_ask_data         = 1'b1;
				m_axis_start_1trans = s_axis_tlast;
				data_to_ps          = data_to_pl;
				data_to_ps_valid    = emptyn_to_pl;
			end
			DMA_AUTO_START: begin
				m_axis_start_1trans = auto_start;
				data_to_ps          = capture_data;
				data_to_ps_valid    = capture_valid;
			end
			DMA_EXT_START: begin
				m_axis_start_1trans = m_axis_start_ext_trigger;
				data_to_ps          = capture_data;
				data_to_ps_valid    = capture_valid;
			end
			default: ; // off
		endcase
	end

endmodule

`default_nettype wire

//--- iq_capture_sequencer.sv
// capture FSM, streams a timestamp header and the buffered samples around each trigger
`timescale 1ns/1ps
`default_nettype none

module iq_capture_sequencer import side_ch_pkg::*; (
	input  logic              clk,
	input  logic              rstn,
	input  logic              iq_capture,
	input  logic              iq_trigger,
	input  logic [TSF_W-1:0]  tsf_runtime_val,
	input  logic [CNT_W-1:0]  pre_trigger_len,
	input  logic [CNT_W-1:0]  iq_len_target,
	input  logic [CNT_W-1:0]  m_axis_data_count,
	ring_if.sequencer         ring,
	output logic [DATA_W-1:0] capture_data,
	output logic              capture_valid
);

	iq_state_e         state;
	logic [TSF_W-1:0]  tsf_lock;
	logic [BUF_AW-1:0] rd_ptr;
	logic [BUF_AW-1:0] rd_ptr_next;
	logic [CNT_W-1:0]  sample_cnt;
	logic [CNT_W:0]    words_needed;
	logic              room_ok;
	logic              start;
	logic              take;

	// header plus samples must fit next to what is already queued
	assign words_needed = {1'b0, m_axis_data_count} + {1'b0, iq_len_target} + 1'b1;
	assign room_ok      = (words_needed <= (CNT_W+1)'(MAX_DMA_UDP));

	assign start = iq_capture && (state == IQ_WAIT) && iq_trigger;
	assign take  = (state == IQ_SAMPLES) && ring.strobe;

	// memory is addressed with the next pointer so rdata tracks rd_ptr
	always_comb begin
		rd_ptr_next = rd_ptr;
		if (start)
			rd_ptr_next = ring.waddr - pre_trigger_len[BUF_AW-1:0];
		else if (take)
			rd_ptr_next = rd_ptr + 1'b1;
	end

	assign ring.raddr = rd_ptr_next;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state         <= IQ_WAIT;
			rd_ptr        <= '0;
			sample_cnt    <= '0;
			capture_valid <= 1'b0;
		end else if (!iq_capture) begin
			capture_valid <= 1'b0; // frozen
		end else begin
			rd_ptr        <= rd_ptr_next;
			capture_valid <= 1'b0;
			case (state)
				IQ_WAIT: begin
					sample_cnt <= '0;
					if (iq_trigger)
						state <= IQ_PREPARE;
				end
				IQ_PREPARE: state <= room_ok ? IQ_HEADER : IQ_WAIT;
				IQ_HEADER: begin
					capture_valid <= 1'b1;
					state         <= (iq_len_target == '0) ? IQ_WAIT : IQ_SAMPLES;
				end
				IQ_SAMPLES: begin
					if (take) begin
						capture_valid <= 1'b1;
						sample_cnt    <= sample_cnt + 1'b1;
						if (sample_cnt == iq_len_target - 1'b1)
							state <= IQ_WAIT;
					end
				end
				default: state <= IQ_WAIT;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start)
			tsf_lock <= tsf_runtime_val;
		if (iq_capture && state == IQ_HEADER)
			capture_data <= tsf_lock;
		else if (take)
			capture_data <= ring.rdata;
	end

endmodule

`default_nettype wire

//--- iq_ring_buffer.sv
// circular sample store, written on every sample strobe and read by the capture sequencer
`timescale 1ns/1ps
`default_nettype none

module iq_ring_buffer import side_ch_pkg::*; (
	input  logic                     clk,
	input  logic                     rstn,
	input  logic                     iq_capture,
	input  logic [0:0]               iq_capture_cfg,
	input  logic [2*IQ_W-1:0]        iq0,
	input  logic [2*IQ_W-1:0]        iq1,
	input  logic                     iq_strobe,
	input  logic signed [RSSI_W-1:0] rssi_half_db,
	input  logic [GPIO_W-1:0]        gpio_status,
	ring_if.buffer                   ring
);

	logic [DATA_W-1:0] mem [0:(1<<BUF_AW)-1];
	logic [DATA_W-1:0] wdata;
	logic [BUF_AW-1:0] wptr;

	// status fields padded to 16 bits each
	always_comb begin
		if (iq_capture_cfg[0] == 1'b0)
			wdata = {{(16-RSSI_W){1'b0}}, rssi_half_db, {(16-GPIO_W){1'b0}}, gpio_status, iq0};
		else
			wdata = {iq1, iq0};
	end

	assign ring.strobe = iq_strobe & iq_capture;
	assign ring.waddr  = wptr;

	always_ff @(posedge clk) begin
		if (!rstn)
			wptr <= '0;
		else if (ring.strobe)
			wptr <= wptr + 1'b1; // wraps at depth
	end

	always_ff @(posedge clk) begin
		if (ring.strobe)
			mem[wptr] <= wdata;
	end

	// registered read port
	always_ff @(posedge clk) begin
		ring.rdata <= mem[ring.raddr];
	end

endmodule

`default_nettype wire

//--- iq_trigger_detect.sv
// trigger stage, turns receiver, FCS, RSSI and AGC status into one capture trigger pulse
`timescale 1ns/1ps
`default_nettype none

module iq_trigger_detect import side_ch_pkg::*; (
	input  logic                     clk,
	input  logic                     rstn,
	input  logic                     iq_capture,
	input  trig_sel_e                iq_trigger_select,
	input  logic                     iq_trigger_free_run_flag,
	input  logic                     fcs_in_strobe,
	input  logic                     fcs_ok,
	input  logic                     long_preamble_detected,
	input  logic                     short_preamble_detected,
	input  logic signed [RSSI_W-1:0] rssi_half_db,
	input  logic signed [RSSI_W-1:0] rssi_th,
	input  logic [GPIO_W-1:0]        gpio_status,
	input  logic [GPIO_W-2:0]        gain_th,
	output logic                     iq_trigger
);

	logic signed [RSSI_W-1:0] rssi_q;
	logic [GPIO_W-1:0]        gpio_q;
	logic                     rssi_rise;
	logic                     rssi_fall;
	logic                     agc_lock_to_unlock;
	logic                     agc_unlock_to_lock;
	logic                     gain_rise;
	logic                     gain_fall;
	logic                     lock_now;
	logic                     lock_prev;
	logic [GPIO_W-2:0]        gain_now;
	logic [GPIO_W-2:0]        gain_prev;
	logic                     trig_next;

	assign lock_now  = gpio_status[GPIO_W-1];
	assign lock_prev = gpio_q[GPIO_W-1];
	assign gain_now  = gpio_status[GPIO_W-2:0];
	assign gain_prev = gpio_q[GPIO_W-2:0];

	// crossing events, one cycle behind the status change
	always_ff @(posedge clk) begin
		if (!rstn) begin
			rssi_q             <= '0;
			gpio_q             <= '0;
			rssi_rise          <= 1'b0;
			rssi_fall          <= 1'b0;
			agc_lock_to_unlock <= 1'b0;
			agc_unlock_to_lock <= 1'b0;
			gain_rise          <= 1'b0;
			gain_fall          <= 1'b0;
		end else if (iq_capture) begin
			rssi_q             <= rssi_half_db;
			gpio_q             <= gpio_status;
			rssi_rise          <= (rssi_q < rssi_th) && (rssi_half_db >= rssi_th);
			rssi_fall          <= (rssi_q >= rssi_th) && (rssi_half_db < rssi_th);
			agc_lock_to_unlock <= lock_prev && !lock_now;
			agc_unlock_to_lock <= !lock_prev && lock_now;
			gain_rise          <= (gain_prev < gain_th) && (gain_now >= gain_th);
			gain_fall          <= (gain_prev >= gain_th) && (gain_now < gain_th);
		end
	end

	always_comb begin
		case (iq_trigger_select)
			TRIG_FCS_OR_FREE:        trig_next = fcs_in_strobe | iq_trigger_free_run_flag;
			TRIG_FCS_OK:             trig_next = fcs_in_strobe & fcs_ok;
			TRIG_FCS_BAD:            trig_next = fcs_in_strobe & ~fcs_ok;
			TRIG_LONG_PREAMBLE:      trig_next = long_preamble_detected;
			TRIG_SHORT_PREAMBLE:     trig_next = short_preamble_detected;
			TRIG_RSSI_RISE:          trig_next = rssi_rise;
			TRIG_RSSI_FALL:          trig_next = rssi_fall;
			TRIG_AGC_LOCK_TO_UNLOCK: trig_next = agc_lock_to_unlock;
			TRIG_AGC_UNLOCK_TO_LOCK: trig_next = agc_unlock_to_lock;
			TRIG_GAIN_RISE:          trig_next = gain_rise;
			TRIG_GAIN_FALL:          trig_next = gain_fall;
			default:                 trig_next = 1'b0; // spare codes
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn)
			iq_trigger <= 1'b0;
		else
			iq_trigger <= iq_capture & trig_next;
	end

endmodule

`default_nettype wire

//--- ring_if.sv
// link between the IQ ring buffer and the capture sequencer, instantiated in the top level
`timescale 1ns/1ps
`default_nettype none

interface ring_if import side_ch_pkg::*; ();

	logic              strobe; // sample written this cycle
	logic [BUF_AW-1:0] waddr;
	logic [BUF_AW-1:0] raddr;
	logic [DATA_W-1:0] rdata;  // mem[raddr], one cycle later

	modport buffer (
		output strobe, waddr, rdata,
		input  raddr
	);

	modport sequencer (
		input  strobe, waddr, rdata,
		output raddr
	);

endinterface

`default_nettype wire

//--- side_ch_pkg.sv
// shared widths, limits and enum types for the IQ side channel capture, imported by every stage
`default_nettype none

package side_ch_pkg;

	localparam int IQ_W   = 16; // one I or Q component
	localparam int GPIO_W = 8;  // agc lock on top bit, gain below
	localparam int RSSI_W = 11; // signed, half dB steps
	localparam int TSF_W  = 64;
	localparam int DATA_W = 64; // dma word

	localparam int BUF_AW = 10; // 1024 sample ring
	localparam int CNT_W  = 14;

	// 65507 byte udp payload / 8 bytes per word
	localparam int MAX_DMA_UDP = 8188;

	localparam int NUM_DMA_REG_ADDR = 2; // dma length register

	typedef enum logic [3:0] {
		TRIG_FCS_OR_FREE        = 4'd0,
		TRIG_FCS_OK             = 4'd1,
		TRIG_FCS_BAD            = 4'd2,
		TRIG_LONG_PREAMBLE      = 4'd3,
		TRIG_SHORT_PREAMBLE     = 4'd4,
		TRIG_RSSI_RISE          = 4'd5,
		TRIG_RSSI_FALL          = 4'd6,
		TRIG_AGC_LOCK_TO_UNLOCK = 4'd7,
		TRIG_AGC_UNLOCK_TO_LOCK = 4'd8,
		TRIG_GAIN_RISE          = 4'd9,
		TRIG_GAIN_FALL          = 4'd10
	} trig_sel_e;

	typedef enum logic [1:0] {
		IQ_WAIT    = 2'd0,
		IQ_PREPARE = 2'd1,
		IQ_HEADER  = 2'd2,
		IQ_SAMPLES = 2'd3
	} iq_state_e;

	typedef enum logic [1:0] {
		DMA_LOOPBACK   = 2'd0,
		DMA_AUTO_START = 2'd1,
		DMA_EXT_START  = 2'd2,
		DMA_OFF        = 2'd3
	} dma_mode_e;

endpackage

`default_nettype wire
